// ==== project.f ====
verilog/RegFilePkg.sv
verilog/RegFileIf.sv
verilog/MultiPortRam.sv
verilog/RegisterFile.sv
verilog/IssueDecoder.sv
verilog/ExecuteUnit.sv
verilog/WritebackStage.sv
verilog/RegFileCore.sv
test/ClockGen.sv
test/regFileCore_assertions.sv
test/RegFileCoreTb.sv

// ==== test/ClockGen.sv ====
//**************************************************************************
// Testbench clock and reset generator
// Free-running clock, active-low reset held for a number of cycles
//**************************************************************************
`timescale 1ns/100ps
`default_nettype none

module ClockGen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Released on a rising edge, so the first sweep step is the next edge
    initial begin
        arstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arstN <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== test/RegFileCoreTb.sv ====
//**************************************************************************
// Table-driven testbench for the register file datapath
// Stimulus table, reference register model, result and debug read
// checks, watchdog
//**************************************************************************
`timescale 1ns/100ps
`default_nettype none

module RegFileCoreTb;
    import RegFilePkg::*;

    localparam int PHYS_REG_NUM  = 32;
    localparam int CLK_PERIOD    = 100;
    localparam int RESET_CYCLES  = 8;
    localparam int MAX_ROWS      = 80;
    localparam int MARGIN_CYCLES = 20;
    localparam int TEST_NUM      = 6;
    localparam logic [31:0] SEED = 32'h5a081b52;

    typedef enum {ROW_IDLE, ROW_ISSUE, ROW_LOAD, ROW_BOTH, ROW_READ} RowKind;

    typedef struct {
        RowKind     kind;
        Instruction instr;
        RegNum      loadDst;
        RegData     loadData;
        RegNum      debugReg;
        bit         checkRead;
        int         test;
    } Row;

    logic       clk;
    logic       arstN;
    logic       issueValid;
    Instruction issueInstr;
    logic       loadValid;
    RegNum      loadDst;
    RegData     loadData;
    RegNum      debugReg;
    RegData     debugData;
    logic       ready;
    logic       resultValid;
    RegNum      resultDst;
    RegData     resultData;
    logic       illegalOp;

    Row     stimTable [MAX_ROWS];
    int     rowNum = 0;
    logic   tableReady = 1'b0;
    // Expected result per row, also the pending ALU write
    logic   expValid [MAX_ROWS];
    logic   expIllegal [MAX_ROWS];
    RegNum  expDst [MAX_ROWS];
    RegData expData [MAX_ROWS];
    logic   aluWrites [MAX_ROWS];
    logic   loadWrites [MAX_ROWS];
    // Program-order state and state as written into the array
    RegData specModel [32];
    RegData regModel [32];
    int     checks [TEST_NUM + 1];
    int     errs [TEST_NUM + 1];
    int     lastRow [TEST_NUM + 1];

    ClockGen #(
        .PERIOD       (CLK_PERIOD),
        .RESET_CYCLES (RESET_CYCLES)
    ) clockGen (
        .clk   (clk),
        .arstN (arstN)
    );

    RegFileCore #(
        .PHYS_REG_NUM (PHYS_REG_NUM)
    ) uut (
        .clk         (clk),
        .arstN       (arstN),
        .issueValid  (issueValid),
        .issueInstr  (issueInstr),
        .loadValid   (loadValid),
        .loadDst     (loadDst),
        .loadData    (loadData),
        .debugReg    (debugReg),
        .debugData   (debugData),
        .ready       (ready),
        .resultValid (resultValid),
        .resultDst   (resultDst),
        .resultData  (resultData),
        .illegalOp   (illegalOp)
    );

    function automatic Instruction makeInstr(input logic [2:0] op, input int dst,
                                             input int srcA, input int srcB);
        return {op, RegNum'(dst), RegNum'(srcA), RegNum'(srcB)};
    endfunction

    function automatic RegData aluModel(input logic [2:0] op, input RegData a, input RegData b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            MOVE:    return a;
            default: return '0;
        endcase
    endfunction

    function automatic string testName(input int t);
        case (t)
            1:       return "sweep and zero reads";
            2:       return "loads and read back";
            3:       return "dependent ALU chain";
            4:       return "write to register 0";
            5:       return "illegal opcodes";
            6:       return "load and issue collision";
            default: return "drain";
        endcase
    endfunction

    task automatic addRow(input RowKind kind, input Instruction instr, input int ldDst,
                          input RegData ldData, input int rdReg, input bit chk, input int test);
        stimTable[rowNum] = '{kind, instr, RegNum'(ldDst), ldData, RegNum'(rdReg), chk, test};
        lastRow[test] = rowNum;
        rowNum++;
    endtask

    task automatic buildTable();
        RegNum ldReg [7];
        for (int r = 0; r < PHYS_REG_NUM; r++) begin
            addRow(ROW_READ, '0, 0, '0, r, 1'b1, 1);
        end
        for (int m = 0; m < 6; m++) begin
            ldReg[m] = RegNum'(1 + ($urandom % (PHYS_REG_NUM - 1)));
        end
        ldReg[6] = '0;
        // Each load is read back at the earliest row that sees it
        for (int m = 0; m < 10; m++) begin
            if (m < 3) begin
                addRow(ROW_LOAD, '0, ldReg[m], $urandom, 0, 1'b0, 2);
            end else if (m < 7) begin
                addRow(ROW_LOAD, '0, ldReg[m], $urandom, ldReg[m - 3], 1'b1, 2);
            end else begin
                addRow(ROW_READ, '0, 0, '0, ldReg[m - 3], 1'b1, 2);
            end
        end
        addRow(ROW_LOAD, '0, 1, $urandom, 0, 1'b0, 3);
        addRow(ROW_LOAD, '0, 2, $urandom, 0, 1'b0, 3);
        addRow(ROW_ISSUE, makeInstr(ADD, 3, 1, 2), 0, '0, 0, 1'b0, 3);
        addRow(ROW_ISSUE, makeInstr(SUB, 4, 3, 1), 0, '0, 0, 1'b0, 3);
        addRow(ROW_ISSUE, makeInstr(AND, 5, 4, 3), 0, '0, 0, 1'b0, 3);
        addRow(ROW_ISSUE, makeInstr(OR, 6, 5, 2), 0, '0, 0, 1'b0, 3);
        addRow(ROW_ISSUE, makeInstr(XOR, 7, 6, 4), 0, '0, 0, 1'b0, 3);
        addRow(ROW_ISSUE, makeInstr(MOVE, 8, 7, 0), 0, '0, 0, 1'b0, 3);
        addRow(ROW_ISSUE, makeInstr(ADD, 0, 1, 2), 0, '0, 0, 1'b0, 4);
        addRow(ROW_IDLE, '0, 0, '0, 0, 1'b0, 4);
        addRow(ROW_IDLE, '0, 0, '0, 0, 1'b0, 4);
        addRow(ROW_READ, '0, 0, '0, 0, 1'b1, 4);
        // Targets hold nonzero values so a stray write shows up
        addRow(ROW_ISSUE, makeInstr(3'd6, 4, 1, 2), 0, '0, 0, 1'b0, 5);
        addRow(ROW_ISSUE, makeInstr(3'd7, 3, 1, 2), 0, '0, 0, 1'b0, 5);
        addRow(ROW_IDLE, '0, 0, '0, 0, 1'b0, 5);
        addRow(ROW_READ, '0, 0, '0, 4, 1'b1, 5);
        addRow(ROW_READ, '0, 0, '0, 3, 1'b1, 5);
        addRow(ROW_BOTH, makeInstr(ADD, 10, 1, 2), 10, $urandom, 0, 1'b0, 6);
        addRow(ROW_ISSUE, makeInstr(ADD, 11, 10, 1), 0, '0, 0, 1'b0, 6);
        addRow(ROW_IDLE, '0, 0, '0, 0, 1'b0, 6);
        addRow(ROW_READ, '0, 0, '0, 10, 1'b1, 6);
        addRow(ROW_READ, '0, 0, '0, 11, 1'b1, 6);
        // Drain so the last results reach the outputs
        addRow(ROW_IDLE, '0, 0, '0, 0, 1'b0, 0);
        addRow(ROW_IDLE, '0, 0, '0, 0, 1'b0, 0);
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp, input int test);
        checks[test]++;
        assert (got === exp) else begin
            $display("FAILED %s: got 0x%h, expected 0x%h (test %0d)", name, got, exp, test);
            errs[test]++;
        end
    endtask

    task automatic driveRow(input Row row);
        issueValid <= (row.kind == ROW_ISSUE) || (row.kind == ROW_BOTH);
        issueInstr <= row.instr;
        loadValid  <= (row.kind == ROW_LOAD) || (row.kind == ROW_BOTH);
        loadDst    <= row.loadDst;
        loadData   <= row.loadData;
        debugReg   <= row.debugReg;
    endtask

    // Sources are read before this row's own writes; the load is applied last
    task automatic predictRow(input int i);
        logic [2:0] op;
        bit         isIssue;
        op = stimTable[i].instr[17:15];
        isIssue = (stimTable[i].kind == ROW_ISSUE) || (stimTable[i].kind == ROW_BOTH);
        expValid[i] = isIssue && (op <= 3'd5);
        expIllegal[i] = isIssue && (op > 3'd5);
        expDst[i] = stimTable[i].instr[14:10];
        expData[i] = aluModel(op, specModel[stimTable[i].instr[9:5]],
                              specModel[stimTable[i].instr[4:0]]);
        aluWrites[i] = expValid[i] && (expDst[i] != '0);
        loadWrites[i] = ((stimTable[i].kind == ROW_LOAD) || (stimTable[i].kind == ROW_BOTH))
                        && (stimTable[i].loadDst != '0);
        if (aluWrites[i]) specModel[expDst[i]] = expData[i];
        if (loadWrites[i]) specModel[stimTable[i].loadDst] = stimTable[i].loadData;
    endtask

    task automatic commitRow(input int j);
        if (aluWrites[j]) regModel[expDst[j]] = expData[j];
        if (loadWrites[j]) regModel[stimTable[j].loadDst] = stimTable[j].loadData;
    endtask

    task automatic checkResult(input int j);
        int t;
        t = stimTable[j].test;
        checkValue("resultValid", resultValid, expValid[j], t);
        checkValue("illegalOp", illegalOp, expIllegal[j], t);
        if (expValid[j]) begin
            checkValue("resultDst", resultDst, expDst[j], t);
            checkValue("resultData", resultData, expData[j], t);
        end
    endtask

    task automatic checkReadyRise(output bit rose);
        int cycles;
        cycles = 0;
        rose = 1'b0;
        while (!rose && cycles < 2 * PHYS_REG_NUM) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
            rose = (ready === 1'b1);
        end
        assert (rose) else begin
            $display("ready did not rise within %0d cycles after reset release", cycles);
            errs[1]++;
        end
        if (rose) checkValue("readyCycles", cycles, PHYS_REG_NUM / 2, 1);
    endtask

    // Row i is sampled one edge later and written three edges later
    task automatic runTable();
        for (int i = 0; i < rowNum; i++) begin
            @(posedge clk);
            driveRow(stimTable[i]);
            predictRow(i);
            if (i >= 3) commitRow(i - 3);
            @(negedge clk);
            if (stimTable[i].checkRead) begin
                checkValue("debugData", debugData, regModel[stimTable[i].debugReg],
                           stimTable[i].test);
            end
            if (i >= 2) checkResult(i - 2);
            for (int t = 1; t <= TEST_NUM; t++) begin
                if (lastRow[t] + 2 == i) begin
                    $display("Test %0d (%s) finished: %0d checks, %0d errors",
                             t, testName(t), checks[t], errs[t]);
                end
            end
        end
    endtask

    initial begin : watchdog
        wait (tableReady);
        #((RESET_CYCLES + PHYS_REG_NUM / 2 + rowNum + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Timeout: the run did not complete in the expected number of cycles");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin : mainFlow
        bit rose;
        int totalChecks;
        int totalErrs;
        issueValid = 1'b0;
        issueInstr = '0;
        loadValid  = 1'b0;
        loadDst    = '0;
        loadData   = '0;
        debugReg   = '0;
        for (int r = 0; r < 32; r++) begin
            specModel[r] = '0;
            regModel[r] = '0;
        end
        for (int t = 0; t <= TEST_NUM; t++) begin
            checks[t] = 0;
            errs[t] = 0;
            lastRow[t] = -10;
        end
        void'($urandom(SEED));
        buildTable();
        tableReady = 1'b1;
        wait (arstN === 1'b1);
        checkReadyRise(rose);
        if (rose) runTable();
        totalChecks = 0;
        totalErrs = uut.portChecks.failCount;
        for (int t = 0; t <= TEST_NUM; t++) begin
            totalChecks += checks[t];
            totalErrs += errs[t];
        end
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 totalChecks, totalErrs, uut.portChecks.failCount);
        if (totalErrs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/regFileCore_assertions.sv ====
//**************************************************************************
// Concurrent assertions on the datapath top-level ports
// Result/illegal exclusivity, quiet outputs before ready, stable ready
//**************************************************************************
`timescale 1ns/100ps
`default_nettype none

module RegFileCoreAssertions (
    input logic clk,
    input logic arstN,
    input logic ready,
    input logic resultValid,
    input logic illegalOp
);

    // Read by the testbench at the end of the run
    int failCount = 0;

    resultExclusive: assert property (@(posedge clk) disable iff (!arstN)
        !(resultValid && illegalOp))
    else begin
        $error("resultValid and illegalOp are high together");
        failCount++;
    end

    quietBeforeReady: assert property (@(posedge clk) disable iff (!arstN)
        !ready |-> (!resultValid && !illegalOp))
    else begin
        $error("result strobe seen while ready is low");
        failCount++;
    end

    readyStable: assert property (@(posedge clk) disable iff (!arstN)
        !$fell(ready))
    else begin
        $error("ready fell while reset is inactive");
        failCount++;
    end

endmodule

bind RegFileCore RegFileCoreAssertions portChecks (
    .clk         (clk),
    .arstN       (arstN),
    .ready       (ready),
    .resultValid (resultValid),
    .illegalOp   (illegalOp)
);

`default_nettype wire

// ==== verilog/ExecuteUnit.sv ====
//**************************************************************************
// Execute stage
// Operand read, bypass from the writeback ports, ALU
//**************************************************************************
`timescale 1ns/100ps
`default_nettype none

module ExecuteUnit (
    DecodedIf.sink                   dec,
    WritebackIf.monitor              wb,
    output RegFilePkg::RegNum  [1:0] readReg,
    input  RegFilePkg::RegData [1:0] readData,
    output RegFilePkg::RegData       aluResult
);
    import RegFilePkg::*;

    RegData operand [2];

    assign readReg[0] = dec.srcA;
    assign readReg[1] = dec.srcB;

    // Load write first, then ALU write, then the array
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (wb.loadWe && (wb.loadDst == readReg[i])) begin
                operand[i] = wb.loadData;
            end else if (wb.aluWe && (wb.aluDst == readReg[i])) begin
                operand[i] = wb.aluData;
            end else begin
                operand[i] = readData[i];
            end
        end
    end

    always_comb begin
        case (dec.op)
            ADD:     aluResult = operand[0] + operand[1];
            SUB:     aluResult = operand[0] - operand[1];
            AND:     aluResult = operand[0] & operand[1];
            OR:      aluResult = operand[0] | operand[1];
            XOR:     aluResult = operand[0] ^ operand[1];
            MOVE:    aluResult = operand[0];
            // Illegal codes never reach writeback
            default: aluResult = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/IssueDecoder.sv ====
//**************************************************************************
// Decode stage
// Instruction field split, illegal opcode check, zero-register filter
//**************************************************************************
`timescale 1ns/100ps
`default_nettype none

module IssueDecoder (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   ready,
    input  logic                   issueValid,
    input  RegFilePkg::Instruction issueInstr,
    input  logic                   loadValid,
    input  RegFilePkg::RegNum      loadDst,
    input  RegFilePkg::RegData     loadData,
    DecodedIf.source               dec,
    output logic                   illegalOp
);
    import RegFilePkg::*;

    logic [2:0] opBits;
    RegNum      instrDst;
    logic       opLegal;
    logic       illegalQ;

    assign opBits   = issueInstr[17:15];
    assign instrDst = issueInstr[14:10];
    assign opLegal  = (opBits <= 3'(MOVE));

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            dec.aluValid  <= 1'b0;
            dec.loadValid <= 1'b0;
            illegalQ      <= 1'b0;
            illegalOp     <= 1'b0;
        end else begin
            dec.aluValid  <= ready && issueValid && opLegal;
            dec.loadValid <= ready && loadValid && (loadDst != '0);
            illegalQ      <= ready && issueValid && !opLegal;
            // Delayed to line up with resultValid
            illegalOp     <= illegalQ;
        end
    end

    always_ff @(posedge clk) begin
        if (ready) begin
            dec.op       <= AluOp'(opBits);
            dec.dst      <= instrDst;
            dec.aluWrite <= (instrDst != '0);
            dec.srcA     <= issueInstr[9:5];
            dec.srcB     <= issueInstr[4:0];
            dec.loadDst  <= loadDst;
            dec.loadData <= loadData;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/MultiPortRam.sv ====
//**************************************************************************
// Distributed multi-port RAM
// Synchronous writes, asynchronous reads, highest write port wins
//**************************************************************************
`timescale 1ns/100ps
`default_nettype none

module MultiPortRam #(
    parameter int ENTRY_NUM   = 32,
    parameter int ENTRY_WIDTH = 32,
    parameter int READ_NUM    = 3,
    parameter int WRITE_NUM   = 2
) (
    input  logic                         clk,
    input  logic                         we [WRITE_NUM],
    input  logic [$clog2(ENTRY_NUM)-1:0] wa [WRITE_NUM],
    input  logic [ENTRY_WIDTH-1:0]       wv [WRITE_NUM],
    input  logic [$clog2(ENTRY_NUM)-1:0] ra [READ_NUM],
    output logic [ENTRY_WIDTH-1:0]       rv [READ_NUM]
);

    logic [ENTRY_WIDTH-1:0] mem [ENTRY_NUM];

    // Later ports overwrite earlier ones on the same address
    always_ff @(posedge clk) begin
        for (int i = 0; i < WRITE_NUM; i++) begin
            if (we[i]) begin
                mem[wa[i]] <= wv[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < READ_NUM; i++) begin
            rv[i] = mem[ra[i]];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/RegFileCore.sv ====
//**************************************************************************
// Datapath top level
// Decode, execute and writeback around the physical register file
//**************************************************************************
`timescale 1ns/100ps
`default_nettype none

module RegFileCore #(
    parameter int PHYS_REG_NUM = 32
) (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   issueValid,
    input  RegFilePkg::Instruction issueInstr,
    input  logic                   loadValid,
    input  RegFilePkg::RegNum      loadDst,
    input  RegFilePkg::RegData     loadData,
    input  RegFilePkg::RegNum      debugReg,
    output RegFilePkg::RegData     debugData,
    output logic                   ready,
    output logic                   resultValid,
    output RegFilePkg::RegNum      resultDst,
    output RegFilePkg::RegData     resultData,
    output logic                   illegalOp
);
    import RegFilePkg::*;

    RegNum  [1:0] exReadReg;
    RegData [2:0] rfReadData;
    RegData       aluResult;

    DecodedIf   dec ();
    WritebackIf wb ();

    IssueDecoder decoder (
        .clk        (clk),
        .arstN      (arstN),
        .ready      (ready),
        .issueValid (issueValid),
        .issueInstr (issueInstr),
        .loadValid  (loadValid),
        .loadDst    (loadDst),
        .loadData   (loadData),
        .dec        (dec.source),
        .illegalOp  (illegalOp)
    );

    ExecuteUnit execute (
        .dec       (dec.sink),
        .wb        (wb.monitor),
        .readReg   (exReadReg),
        .readData  (rfReadData[1:0]),
        .aluResult (aluResult)
    );

    WritebackStage writeback (
        .clk         (clk),
        .arstN       (arstN),
        .dec         (dec.sink),
        .aluResult   (aluResult),
        .wb          (wb.source),
        .resultValid (resultValid),
        .resultDst   (resultDst),
        .resultData  (resultData)
    );

    // Read port 2 serves the debug read
    RegisterFile #(
        .PHYS_REG_NUM (PHYS_REG_NUM)
    ) regFile (
        .clk      (clk),
        .arstN    (arstN),
        .wb       (wb.sink),
        .readReg  ({debugReg, exReadReg}),
        .readData (rfReadData),
        .ready    (ready)
    );

    assign debugData = rfReadData[2];

endmodule

`default_nettype wire

// ==== verilog/RegFileIf.sv ====
//**************************************************************************
// Stage interfaces
// DecodedIf carries the decoded instruction and load request,
// WritebackIf carries both register file write ports
//**************************************************************************
`timescale 1ns/100ps
`default_nettype none

interface DecodedIf;
    import RegFilePkg::*;

    logic   aluValid;
    AluOp   op;
    RegNum  dst;
    logic   aluWrite;
    RegNum  srcA;
    RegNum  srcB;
    logic   loadValid;
    RegNum  loadDst;
    RegData loadData;

    modport source (
        output aluValid, op, dst, aluWrite, srcA, srcB,
        output loadValid, loadDst, loadData
    );

    modport sink (
        input aluValid, op, dst, aluWrite, srcA, srcB,
        input loadValid, loadDst, loadData
    );
endinterface

interface WritebackIf;
    import RegFilePkg::*;

    // Port 0 is the ALU write, port 1 the load write
    logic   aluWe;
    RegNum  aluDst;
    RegData aluData;
    logic   loadWe;
    RegNum  loadDst;
    RegData loadData;

    modport source  (output aluWe, aluDst, aluData, loadWe, loadDst, loadData);
    modport sink    (input  aluWe, aluDst, aluData, loadWe, loadDst, loadData);
    // Bypass taps
    modport monitor (input  aluWe, aluDst, aluData, loadWe, loadDst, loadData);
endinterface

`default_nettype wire

// ==== verilog/RegFilePkg.sv ====
//**************************************************************************
// Shared types of the register file datapath
// Data and register-number widths, instruction word, ALU opcodes and
// the init sweep states
//**************************************************************************
`default_nettype none

package RegFilePkg;

    localparam int DATA_WIDTH    = 32;
    localparam int REG_NUM_WIDTH = 5;
    localparam int INSTR_WIDTH   = 18;

    typedef logic [DATA_WIDTH-1:0]    RegData;
    typedef logic [REG_NUM_WIDTH-1:0] RegNum;

    // {op[17:15], dst[14:10], srcA[9:5], srcB[4:0]}
    typedef logic [INSTR_WIDTH-1:0]   Instruction;

    // Codes 6 and 7 are illegal
    typedef enum logic [2:0] {
        ADD  = 3'd0,
        SUB  = 3'd1,
        AND  = 3'd2,
        OR   = 3'd3,
        XOR  = 3'd4,
        MOVE = 3'd5
    } AluOp;

    typedef enum logic {
        INIT_SWEEP = 1'b0,
        INIT_DONE  = 1'b1
    } InitState;

endpackage

`default_nettype wire

// ==== verilog/RegisterFile.sv ====
//**************************************************************************
// Physical register file
// Reset sweep FSM, write-port mux and three asynchronous read ports
//**************************************************************************
`timescale 1ns/100ps
`default_nettype none

module RegisterFile #(
    parameter int PHYS_REG_NUM = 32
) (
    input  logic                     clk,
    input  logic                     arstN,
    WritebackIf.sink                 wb,
    input  RegFilePkg::RegNum  [2:0] readReg,
    output RegFilePkg::RegData [2:0] readData,
    output logic                     ready
);
    import RegFilePkg::*;

    localparam int ADDR_WIDTH = $clog2(PHYS_REG_NUM);
    localparam int READ_NUM   = 3;
    localparam int WRITE_NUM  = 2;

    InitState              state;
    RegNum                 sweepIdx;
    logic                  ramWe [WRITE_NUM];
    logic [ADDR_WIDTH-1:0] ramWa [WRITE_NUM];
    RegData                ramWv [WRITE_NUM];
    logic [ADDR_WIDTH-1:0] ramRa [READ_NUM];
    RegData                ramRv [READ_NUM];

    MultiPortRam #(
        .ENTRY_NUM   (PHYS_REG_NUM),
        .ENTRY_WIDTH ($bits(RegData)),
        .READ_NUM    (READ_NUM),
        .WRITE_NUM   (WRITE_NUM)
    ) phyReg (
        .clk (clk),
        .we  (ramWe),
        .wa  (ramWa),
        .wv  (ramWv),
        .ra  (ramRa),
        .rv  (ramRv)
    );

    // Sweep clears one pair of entries per cycle
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state    <= INIT_SWEEP;
            sweepIdx <= '0;
        end else if (state == INIT_SWEEP) begin
            sweepIdx <= sweepIdx + RegNum'(WRITE_NUM);
            if (sweepIdx == RegNum'(PHYS_REG_NUM - WRITE_NUM)) begin
                state <= INIT_DONE;
            end
        end
    end

    assign ready = (state == INIT_DONE);

    always_comb begin
        ramWe[0] = wb.aluWe;
        ramWa[0] = wb.aluDst[ADDR_WIDTH-1:0];
        ramWv[0] = wb.aluData;
        // Load on the higher port so it wins a collision
        ramWe[1] = wb.loadWe;
        ramWa[1] = wb.loadDst[ADDR_WIDTH-1:0];
        ramWv[1] = wb.loadData;
        if (state == INIT_SWEEP) begin
            for (int i = 0; i < WRITE_NUM; i++) begin
                ramWe[i] = 1'b1;
                ramWa[i] = ADDR_WIDTH'(sweepIdx + RegNum'(i));
                ramWv[i] = '0;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < READ_NUM; i++) begin
            ramRa[i]    = readReg[i][ADDR_WIDTH-1:0];
            readData[i] = ramRv[i];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/WritebackStage.sv ====
//**************************************************************************
// Writeback stage
// Result registers driving both write ports and the result outputs
//**************************************************************************
`timescale 1ns/100ps
`default_nettype none

module WritebackStage (
    input  logic               clk,
    input  logic               arstN,
    DecodedIf.sink             dec,
    input  RegFilePkg::RegData aluResult,
    WritebackIf.source         wb,
    output logic               resultValid,
    output RegFilePkg::RegNum  resultDst,
    output RegFilePkg::RegData resultData
);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wb.aluWe    <= 1'b0;
            wb.loadWe   <= 1'b0;
            resultValid <= 1'b0;
        end else begin
            wb.aluWe    <= dec.aluValid && dec.aluWrite;
            wb.loadWe   <= dec.loadValid;
            // Reported even for a write to register 0
            resultValid <= dec.aluValid;
        end
    end

    always_ff @(posedge clk) begin
        wb.aluDst   <= dec.dst;
        wb.aluData  <= aluResult;
        wb.loadDst  <= dec.loadDst;
        wb.loadData <= dec.loadData;
    end

    assign resultDst  = wb.aluDst;
    assign resultData = wb.aluData;

endmodule

`default_nettype wire
